// ==== filelist.f ====
+incdir+include
source/rob_types_pkg.sv
source/alu_unit.sv
source/mult_unit.sv
source/branch_unit.sv
source/cdb_arbiter.sv
source/reorder_buffer.sv
source/rob_core_top.sv
testbench/rob_core_asserts.sv
testbench/rob_core_tb.sv

// ==== include/rob_params.svh ====
`ifndef ROB_PARAMS_SVH
`define ROB_PARAMS_SVH

// operand and result width
`define XLEN 32

// reorder buffer entries, tag is an entry index
`define ROB_DEPTH 8
`define TAG_W 3

// cycles the multiplier stays in its busy state
`define MUL_LAT 3

`endif

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the reorder buffer testbench with Verilator from the project root
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	-f filelist.f --top-module rob_core_tb -o rob_core_sim

sim_out=$(./obj_dir/rob_core_sim 2>&1) || true
echo "$sim_out"

if grep -q "NO ERRORS" <<< "$sim_out"; then
	echo "simulation passed"
else
	echo "simulation failed"
	exit 1
fi

// ==== source/alu_unit.sv ====
`timescale 1ns/1ps
`include "rob_params.svh"

module alu_unit (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   load_i,
	input  rob_types_pkg::opcode_t op_i,
	input  logic [`XLEN-1:0]       a_i,
	input  logic [`XLEN-1:0]       b_i,
	input  logic [`TAG_W-1:0]      tag_i,
	input  logic                   flush_i,
	input  logic                   grant_i,
	output logic                   req_o,
	output logic [`TAG_W-1:0]      tag_o,
	output logic [`XLEN-1:0]       data_o,
	output logic                   busy_o
);
	import rob_types_pkg::*;

	logic pending;

	// request stays up until the bus takes it
	always_ff @(posedge clk) begin
		if (rst || flush_i) begin
			pending <= 1'b0;
		end else if (load_i) begin
			pending <= 1'b1;
		end else if (grant_i) begin
			pending <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (load_i) begin
			tag_o <= tag_i;
			case (op_i)
				op_sub:  data_o <= a_i - b_i;
				op_xor:  data_o <= a_i ^ b_i;
				default: data_o <= a_i + b_i;
			endcase
		end
	end

	assign req_o  = pending;
	assign busy_o = pending;

endmodule : alu_unit

// ==== source/branch_unit.sv ====
`timescale 1ns/1ps
`include "rob_params.svh"

module branch_unit (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   load_i,
	input  rob_types_pkg::opcode_t op_i,
	input  logic [`XLEN-1:0]       a_i,
	input  logic [`XLEN-1:0]       b_i,
	input  logic [`XLEN-1:0]       imm_i,
	input  logic [`XLEN-1:0]       pc_i,
	input  logic [`TAG_W-1:0]      tag_i,
	input  logic                   flush_i,
	input  logic                   grant_i,
	output logic                   req_o,
	output logic [`TAG_W-1:0]      tag_o,
	output logic [`XLEN-1:0]       data_o,
	output logic                   taken_o,
	output logic                   busy_o
);
	import rob_types_pkg::*;

	logic pending;
	logic cond;

	// bne is the inverse of beq
	assign cond = (op_i == op_bne) ? (a_i != b_i) : (a_i == b_i);

	always_ff @(posedge clk) begin
		if (rst || flush_i) begin
			pending <= 1'b0;
		end else if (load_i) begin
			pending <= 1'b1;
		end else if (grant_i) begin
			pending <= 1'b0;
		end
	end

	// next pc goes out on the data lines
	always_ff @(posedge clk) begin
		if (load_i) begin
			tag_o   <= tag_i;
			taken_o <= cond;
			data_o  <= cond ? (pc_i + imm_i) : (pc_i + `XLEN'd4);
		end
	end

	assign req_o  = pending;
	assign busy_o = pending;

endmodule : branch_unit

// ==== source/cdb_arbiter.sv ====
`timescale 1ns/1ps
`include "rob_params.svh"

module cdb_arbiter (
	input  logic              clk,
	input  logic              rst,
	input  logic              alu_req_i,
	input  logic [`TAG_W-1:0] alu_tag_i,
	input  logic [`XLEN-1:0]  alu_data_i,
	input  logic              mult_req_i,
	input  logic [`TAG_W-1:0] mult_tag_i,
	input  logic [`XLEN-1:0]  mult_data_i,
	input  logic              br_req_i,
	input  logic [`TAG_W-1:0] br_tag_i,
	input  logic [`XLEN-1:0]  br_data_i,
	input  logic              br_taken_i,
	output logic              alu_grant_o,
	output logic              mult_grant_o,
	output logic              br_grant_o,
	output logic              cdb_valid_o,
	output logic [`TAG_W-1:0] cdb_tag_o,
	output logic [`XLEN-1:0]  cdb_data_o,
	output logic              cdb_taken_o
);
	localparam int N_UNITS = 3;

	// bit 0 alu, bit 1 mult, bit 2 branch
	logic [N_UNITS-1:0] req_vec;
	logic [N_UNITS-1:0] gnt_vec;
	logic [1:0]         prio;
	logic [1:0]         cand;
	logic [1:0]         gnt_idx;

	function automatic logic [1:0] next_unit(input logic [1:0] u);
		return (u == 2'd2) ? 2'd0 : u + 2'd1;
	endfunction

	assign req_vec = {br_req_i, mult_req_i, alu_req_i};

	// search starts at the unit holding priority
	always_comb begin
		gnt_vec = '0;
		gnt_idx = prio;
		cand    = prio;
		for (int i = 0; i < N_UNITS; i++) begin
			if (req_vec[cand] && gnt_vec == '0) begin
				gnt_vec[cand] = 1'b1;
				gnt_idx       = cand;
			end
			cand = next_unit(cand);
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			prio <= 2'd0;
		end else if (|gnt_vec) begin
			prio <= next_unit(gnt_idx);
		end
	end

	assign alu_grant_o  = gnt_vec[0];
	assign mult_grant_o = gnt_vec[1];
	assign br_grant_o   = gnt_vec[2];

	always_comb begin
		cdb_tag_o  = '0;
		cdb_data_o = '0;
		case (gnt_vec)
			3'b001: begin
				cdb_tag_o  = alu_tag_i;
				cdb_data_o = alu_data_i;
			end
			3'b010: begin
				cdb_tag_o  = mult_tag_i;
				cdb_data_o = mult_data_i;
			end
			3'b100: begin
				cdb_tag_o  = br_tag_i;
				cdb_data_o = br_data_i;
			end
			default: ;
		endcase
	end

	assign cdb_valid_o = |gnt_vec;
	assign cdb_taken_o = gnt_vec[2] & br_taken_i;

endmodule : cdb_arbiter

// ==== source/mult_unit.sv ====
`timescale 1ns/1ps
`include "rob_params.svh"

module mult_unit (
	input  logic              clk,
	input  logic              rst,
	input  logic              load_i,
	input  logic [`XLEN-1:0]  a_i,
	input  logic [`XLEN-1:0]  b_i,
	input  logic [`TAG_W-1:0] tag_i,
	input  logic              flush_i,
	input  logic              grant_i,
	output logic              req_o,
	output logic [`TAG_W-1:0] tag_o,
	output logic [`XLEN-1:0]  data_o,
	output logic              busy_o
);
	import rob_types_pkg::*;

	localparam int CNT_W = $clog2(`MUL_LAT + 1);

	mult_state_t      state;
	logic [CNT_W-1:0] cycle_cnt;
	logic [`XLEN-1:0] op_a;
	logic [`XLEN-1:0] op_b;

	always_ff @(posedge clk) begin
		if (rst || flush_i) begin
			state     <= mult_idle;
			cycle_cnt <= '0;
		end else begin
			case (state)
				mult_idle: begin
					if (load_i) begin
						state     <= mult_busy;
						cycle_cnt <= '0;
					end
				end
				mult_busy: begin
					// leave after MUL_LAT cycles in here
					if (cycle_cnt == CNT_W'(`MUL_LAT - 1)) begin
						state <= mult_done;
					end else begin
						cycle_cnt <= cycle_cnt + 1'b1;
					end
				end
				mult_done: begin
					if (grant_i) begin
						state <= mult_idle;
					end
				end
				default: state <= mult_idle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (load_i) begin
			op_a  <= a_i;
			op_b  <= b_i;
			tag_o <= tag_i;
		end
		// low XLEN bits of the product only
		if (state == mult_busy) begin
			data_o <= op_a * op_b;
		end
	end

	assign req_o  = (state == mult_done);
	assign busy_o = (state != mult_idle);

endmodule : mult_unit

// ==== source/reorder_buffer.sv ====
`timescale 1ns/1ps
`include "rob_params.svh"

module reorder_buffer (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 dispatch_valid_i,
	input  rob_types_pkg::opcode_t dispatch_op_i,
	input  logic [`XLEN-1:0]     dispatch_pc_i,
	input  logic [4:0]           dispatch_rd_i,
	input  logic                 dispatch_pred_i,
	input  logic                 alu_busy_i,
	input  logic                 mult_busy_i,
	input  logic                 br_busy_i,
	output logic                 dispatch_ready_o,
	output logic                 alu_load_o,
	output logic                 mult_load_o,
	output logic                 br_load_o,
	output logic [`TAG_W-1:0]    issue_tag_o,
	input  logic                 cdb_valid_i,
	input  logic [`TAG_W-1:0]    cdb_tag_i,
	input  logic [`XLEN-1:0]     cdb_data_i,
	input  logic                 cdb_taken_i,
	output logic                 unit_flush_o,
	output logic                 commit_valid_o,
	output logic [4:0]           commit_rd_o,
	output logic [`XLEN-1:0]     commit_data_o,
	output logic                 br_valid_o,
	output logic                 br_taken_o,
	output logic [`XLEN-1:0]     br_pc_o,
	output logic                 flush_valid_o,
	output logic [`XLEN-1:0]     flush_pc_o
);
	import rob_types_pkg::*;

	// entry storage
	opcode_t          ent_op    [`ROB_DEPTH];
	logic [`XLEN-1:0] ent_pc    [`ROB_DEPTH];
	logic [4:0]       ent_rd    [`ROB_DEPTH];
	logic             ent_pred  [`ROB_DEPTH];
	logic [`XLEN-1:0] ent_data  [`ROB_DEPTH];
	logic             ent_taken [`ROB_DEPTH];
	logic             ent_ready [`ROB_DEPTH];
	logic             ent_valid [`ROB_DEPTH];

	logic [`TAG_W-1:0] head;
	logic [`TAG_W-1:0] tail;
	logic [`TAG_W:0]   count;

	logic full;
	logic alu_sel;
	logic mult_sel;
	logic br_sel;
	logic unit_free;
	logic fire;
	logic retire;
	logic head_is_br;
	logic head_mispred;

	// route the incoming opcode to its unit
	always_comb begin
		alu_sel  = 1'b0;
		mult_sel = 1'b0;
		br_sel   = 1'b0;
		case (dispatch_op_i)
			op_add, op_sub, op_xor: alu_sel = 1'b1;
			op_mul:                 mult_sel = 1'b1;
			op_beq, op_bne:         br_sel = 1'b1;
			default: ;
		endcase
	end

	assign full      = (count == `ROB_DEPTH);
	assign unit_free = (alu_sel & ~alu_busy_i) | (mult_sel & ~mult_busy_i) | (br_sel & ~br_busy_i);

	assign retire       = ent_valid[head] & ent_ready[head];
	assign head_is_br   = (ent_op[head] == op_beq) || (ent_op[head] == op_bne);
	// branches resolve only at the head, so a wrong guess kills everything younger
	assign head_mispred = retire & head_is_br & (ent_taken[head] != ent_pred[head]);

	assign dispatch_ready_o = ~full & unit_free & ~head_mispred;
	assign fire             = dispatch_valid_i & dispatch_ready_o;

	assign alu_load_o   = fire & alu_sel;
	assign mult_load_o  = fire & mult_sel;
	assign br_load_o    = fire & br_sel;
	assign issue_tag_o  = tail;
	assign unit_flush_o = head_mispred;

	// pointers and entry status
	always_ff @(posedge clk) begin
		if (rst || head_mispred) begin
			head  <= '0;
			tail  <= '0;
			count <= '0;
			for (int i = 0; i < `ROB_DEPTH; i++) begin
				ent_valid[i] <= 1'b0;
				ent_ready[i] <= 1'b0;
			end
		end else begin
			if (fire) begin
				ent_valid[tail] <= 1'b1;
				ent_ready[tail] <= 1'b0;
				tail            <= tail + 1'b1;
			end
			// results only land on live entries
			if (cdb_valid_i && ent_valid[cdb_tag_i]) begin
				ent_ready[cdb_tag_i] <= 1'b1;
			end
			if (retire) begin
				ent_valid[head] <= 1'b0;
				ent_ready[head] <= 1'b0;
				head            <= head + 1'b1;
			end
			case ({fire, retire})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// entry payload
	always_ff @(posedge clk) begin
		if (fire) begin
			ent_op[tail]   <= dispatch_op_i;
			ent_pc[tail]   <= dispatch_pc_i;
			ent_rd[tail]   <= dispatch_rd_i;
			ent_pred[tail] <= dispatch_pred_i;
		end
		if (cdb_valid_i) begin
			ent_data[cdb_tag_i]  <= cdb_data_i;
			ent_taken[cdb_tag_i] <= cdb_taken_i;
		end
	end

	// registered retire outputs, one cycle wide
	always_ff @(posedge clk) begin
		if (rst) begin
			commit_valid_o <= 1'b0;
			br_valid_o     <= 1'b0;
			flush_valid_o  <= 1'b0;
		end else begin
			commit_valid_o <= retire & ~head_is_br;
			br_valid_o     <= retire & head_is_br;
			flush_valid_o  <= head_mispred;
		end
	end

	// br_pc_o is the branch's own address, flush_pc_o the resolved next pc
	always_ff @(posedge clk) begin
		if (retire) begin
			commit_rd_o   <= ent_rd[head];
			commit_data_o <= ent_data[head];
			br_taken_o    <= ent_taken[head];
			br_pc_o       <= ent_pc[head];
			flush_pc_o    <= ent_data[head];
		end
	end

endmodule : reorder_buffer

// ==== source/rob_core_top.sv ====
`timescale 1ns/1ps
`include "rob_params.svh"

module rob_core_top (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   dispatch_valid_i,
	input  rob_types_pkg::opcode_t dispatch_op_i,
	input  logic [`XLEN-1:0]       dispatch_a_i,
	input  logic [`XLEN-1:0]       dispatch_b_i,
	input  logic [`XLEN-1:0]       dispatch_imm_i,
	input  logic [`XLEN-1:0]       dispatch_pc_i,
	input  logic [4:0]             dispatch_rd_i,
	input  logic                   dispatch_pred_i,
	output logic                   dispatch_ready_o,
	output logic                   commit_valid_o,
	output logic [4:0]             commit_rd_o,
	output logic [`XLEN-1:0]       commit_data_o,
	output logic                   br_valid_o,
	output logic                   br_taken_o,
	output logic [`XLEN-1:0]       br_pc_o,
	output logic                   flush_valid_o,
	output logic [`XLEN-1:0]       flush_pc_o
);
	logic alu_load, mult_load, br_load;
	logic alu_busy, mult_busy, br_busy;
	logic alu_req, mult_req, br_req;
	logic alu_grant, mult_grant, br_grant;
	logic unit_flush;
	logic br_taken;
	logic cdb_valid;
	logic cdb_taken;
	logic [`TAG_W-1:0] issue_tag;
	logic [`TAG_W-1:0] alu_tag, mult_tag, br_tag, cdb_tag;
	logic [`XLEN-1:0]  alu_data, mult_data, br_data, cdb_data;

	reorder_buffer u_rob (
		.clk, .rst,
		.dispatch_valid_i, .dispatch_op_i, .dispatch_pc_i, .dispatch_rd_i, .dispatch_pred_i,
		.alu_busy_i(alu_busy), .mult_busy_i(mult_busy), .br_busy_i(br_busy),
		.dispatch_ready_o,
		.alu_load_o(alu_load), .mult_load_o(mult_load), .br_load_o(br_load),
		.issue_tag_o(issue_tag),
		.cdb_valid_i(cdb_valid), .cdb_tag_i(cdb_tag), .cdb_data_i(cdb_data),
		.cdb_taken_i(cdb_taken),
		.unit_flush_o(unit_flush),
		.commit_valid_o, .commit_rd_o, .commit_data_o,
		.br_valid_o, .br_taken_o, .br_pc_o,
		.flush_valid_o, .flush_pc_o
	);

	// operands come straight from the dispatch port
	alu_unit u_alu (
		.clk, .rst, .load_i(alu_load), .op_i(dispatch_op_i),
		.a_i(dispatch_a_i), .b_i(dispatch_b_i), .tag_i(issue_tag),
		.flush_i(unit_flush), .grant_i(alu_grant),
		.req_o(alu_req), .tag_o(alu_tag), .data_o(alu_data), .busy_o(alu_busy)
	);

	mult_unit u_mult (
		.clk, .rst, .load_i(mult_load),
		.a_i(dispatch_a_i), .b_i(dispatch_b_i), .tag_i(issue_tag),
		.flush_i(unit_flush), .grant_i(mult_grant),
		.req_o(mult_req), .tag_o(mult_tag), .data_o(mult_data), .busy_o(mult_busy)
	);

	branch_unit u_br (
		.clk, .rst, .load_i(br_load), .op_i(dispatch_op_i),
		.a_i(dispatch_a_i), .b_i(dispatch_b_i), .imm_i(dispatch_imm_i), .pc_i(dispatch_pc_i),
		.tag_i(issue_tag), .flush_i(unit_flush), .grant_i(br_grant),
		.req_o(br_req), .tag_o(br_tag), .data_o(br_data), .taken_o(br_taken),
		.busy_o(br_busy)
	);

	cdb_arbiter u_arb (
		.clk, .rst,
		.alu_req_i(alu_req), .alu_tag_i(alu_tag), .alu_data_i(alu_data),
		.mult_req_i(mult_req), .mult_tag_i(mult_tag), .mult_data_i(mult_data),
		.br_req_i(br_req), .br_tag_i(br_tag), .br_data_i(br_data), .br_taken_i(br_taken),
		.alu_grant_o(alu_grant), .mult_grant_o(mult_grant), .br_grant_o(br_grant),
		.cdb_valid_o(cdb_valid), .cdb_tag_o(cdb_tag), .cdb_data_o(cdb_data),
		.cdb_taken_o(cdb_taken)
	);

endmodule : rob_core_top

// ==== source/rob_types_pkg.sv ====
package rob_types_pkg;

	// decoded operation, also selects the execution unit
	typedef enum logic [2:0] {
		op_add = 3'd0,
		op_sub = 3'd1,
		op_xor = 3'd2,
		op_mul = 3'd3,
		op_beq = 3'd4,
		op_bne = 3'd5
	} opcode_t;

	// multiplier sequencing
	typedef enum logic [1:0] {
		mult_idle = 2'd0,
		mult_busy = 2'd1,
		mult_done = 2'd2
	} mult_state_t;

endpackage : rob_types_pkg

// ==== testbench/rob_core_asserts.sv ====
`timescale 1ns/1ps

module rob_core_asserts (
	input logic clk,
	input logic rst,
	input logic alu_grant_i,
	input logic mult_grant_i,
	input logic br_grant_i,
	input logic alu_load_i,
	input logic mult_load_i,
	input logic br_load_i,
	input logic alu_busy_i,
	input logic mult_busy_i,
	input logic br_busy_i,
	input logic commit_valid_i,
	input logic br_valid_i,
	input logic flush_valid_i
);

	// one winner on the result bus per cycle
	grant_onehot: assert property (@(posedge clk) disable iff (rst)
		$onehot0({alu_grant_i, mult_grant_i, br_grant_i}))
		else $error("more than one unit granted the result bus");

	// the unit started by a dispatch is busy in the following cycle
	load_sets_busy: assert property (@(posedge clk) disable iff (rst)
		(alu_load_i || mult_load_i || br_load_i) |=>
			|({alu_busy_i, mult_busy_i, br_busy_i} & $past({alu_load_i, mult_load_i, br_load_i})))
		else $error("a unit started by a dispatch did not report busy");

	// a flush only comes with the branch that caused it
	flush_with_branch: assert property (@(posedge clk) disable iff (rst)
		flush_valid_i |-> br_valid_i)
		else $error("flush raised without a branch report");

	// retire outputs are cleared by the reset edge
	quiet_in_reset: assert property (@(posedge clk)
		rst |=> (!commit_valid_i && !br_valid_i && !flush_valid_i))
		else $error("retire outputs active during reset");

endmodule : rob_core_asserts

bind rob_core_top rob_core_asserts u_asserts (
	.clk(clk),
	.rst(rst),
	.alu_grant_i(alu_grant),
	.mult_grant_i(mult_grant),
	.br_grant_i(br_grant),
	.alu_load_i(alu_load),
	.mult_load_i(mult_load),
	.br_load_i(br_load),
	.alu_busy_i(alu_busy),
	.mult_busy_i(mult_busy),
	.br_busy_i(br_busy),
	.commit_valid_i(commit_valid_o),
	.br_valid_i(br_valid_o),
	.flush_valid_i(flush_valid_o)
);

// ==== testbench/rob_core_tb.sv ====
`timescale 1ns/1ps
`include "rob_params.svh"

module rob_core_tb;
	import rob_types_pkg::*;

	localparam int MAX_LINES = 32;
	localparam string DATA_FILE = "testbench/rob_testdata.txt";

	logic             clk;
	logic             rst;
	logic             dispatch_valid;
	opcode_t          dispatch_op;
	logic [`XLEN-1:0] dispatch_a;
	logic [`XLEN-1:0] dispatch_b;
	logic [`XLEN-1:0] dispatch_imm;
	logic [`XLEN-1:0] dispatch_pc;
	logic [4:0]       dispatch_rd;
	logic             dispatch_pred;
	logic             dispatch_ready;
	logic             commit_valid;
	logic [4:0]       commit_rd;
	logic [`XLEN-1:0] commit_data;
	logic             br_valid;
	logic             br_taken;
	logic [`XLEN-1:0] br_pc;
	logic             flush_valid;
	logic [`XLEN-1:0] flush_pc;

	// instruction table read from the data file
	opcode_t          line_op   [MAX_LINES];
	logic [`XLEN-1:0] line_a    [MAX_LINES];
	logic [`XLEN-1:0] line_b    [MAX_LINES];
	logic [`XLEN-1:0] line_imm  [MAX_LINES];
	logic [`XLEN-1:0] line_pc   [MAX_LINES];
	logic [4:0]       line_rd   [MAX_LINES];
	logic             line_pred [MAX_LINES];
	logic [`XLEN-1:0] line_exp  [MAX_LINES];
	int               n_lines;

	// line indices of accepted instructions, oldest first
	int sb_q[$];
	int retired;
	int cycle_count;
	int cycle_limit;
	integer seed;

	rob_core_top DUT (
		.clk(clk),
		.rst(rst),
		.dispatch_valid_i(dispatch_valid),
		.dispatch_op_i(dispatch_op),
		.dispatch_a_i(dispatch_a),
		.dispatch_b_i(dispatch_b),
		.dispatch_imm_i(dispatch_imm),
		.dispatch_pc_i(dispatch_pc),
		.dispatch_rd_i(dispatch_rd),
		.dispatch_pred_i(dispatch_pred),
		.dispatch_ready_o(dispatch_ready),
		.commit_valid_o(commit_valid),
		.commit_rd_o(commit_rd),
		.commit_data_o(commit_data),
		.br_valid_o(br_valid),
		.br_taken_o(br_taken),
		.br_pc_o(br_pc),
		.flush_valid_o(flush_valid),
		.flush_pc_o(flush_pc)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	task automatic end_with_failure();
		$display("ERRORS FOUND");
		$fatal(1, "simulation stopped after an error");
	endtask

	task automatic report_mismatch(input string msg);
		$display("CHECK FAILED time=%0t %s", $time, msg);
		end_with_failure();
	endtask

	task automatic abort_run(input string msg);
		$display("%s", msg);
		end_with_failure();
	endtask

	task automatic check_commit(input logic [4:0] got_rd, input logic [4:0] exp_rd,
		input logic [`XLEN-1:0] got_data, input logic [`XLEN-1:0] exp_data, input int idx);
		if (got_rd !== exp_rd || got_data !== exp_data) begin
			report_mismatch($sformatf("commit of line %0d: rd %0d data %h, expected rd %0d data %h",
				idx, got_rd, got_data, exp_rd, exp_data));
		end
	endtask

	task automatic check_branch(input logic got_taken, input logic exp_taken,
		input logic [`XLEN-1:0] got_pc, input logic [`XLEN-1:0] exp_pc, input int idx);
		if (got_taken !== exp_taken || got_pc !== exp_pc) begin
			report_mismatch($sformatf("branch of line %0d: taken %b pc %h, expected taken %b pc %h",
				idx, got_taken, got_pc, exp_taken, exp_pc));
		end
	endtask

	task automatic check_flush(input logic [`XLEN-1:0] got_pc, input logic [`XLEN-1:0] exp_pc,
		input int idx);
		if (got_pc !== exp_pc) begin
			report_mismatch($sformatf("flush after line %0d: pc %h, expected %h",
				idx, got_pc, exp_pc));
		end
	endtask

	// beq and bne semantics
	function automatic logic branch_taken(input opcode_t op, input logic [`XLEN-1:0] a,
		input logic [`XLEN-1:0] b);
		return (op == op_beq) ? (a == b) : (a != b);
	endfunction

	function automatic logic is_branch(input opcode_t op);
		return (op == op_beq) || (op == op_bne);
	endfunction

	task automatic parse_mnemonic(input string m, output opcode_t op, output logic ok);
		ok = 1'b1;
		op = op_add;
		case (m)
			"add": op = op_add;
			"sub": op = op_sub;
			"xor": op = op_xor;
			"mul": op = op_mul;
			"beq": op = op_beq;
			"bne": op = op_bne;
			default: ok = 1'b0;
		endcase
	endtask

	task automatic load_testdata();
		int fd;
		int code;
		string text;
		string mnem;
		opcode_t op;
		logic ok;
		logic [31:0] f_a, f_b, f_imm, f_pc, f_rd, f_pred, f_exp;
		fd = $fopen(DATA_FILE, "r");
		if (fd == 0) begin
			abort_run({"cannot open the stimulus file ", DATA_FILE});
		end
		n_lines = 0;
		while (!$feof(fd)) begin
			text = "";
			mnem = "";
			if ($fgets(text, fd) == 0) begin
				break;
			end
			code = $sscanf(text, "%s %h %h %h %h %h %h %h", mnem, f_a, f_b, f_imm, f_pc,
				f_rd, f_pred, f_exp);
			// comment lines start with a lone hash
			if (code == 8) begin
				parse_mnemonic(mnem, op, ok);
				if (!ok || n_lines >= MAX_LINES) begin
					abort_run({"bad or excess stimulus line: ", text});
				end
				line_op[n_lines]   = op;
				line_a[n_lines]    = f_a;
				line_b[n_lines]    = f_b;
				line_imm[n_lines]  = f_imm;
				line_pc[n_lines]   = f_pc;
				line_rd[n_lines]   = f_rd[4:0];
				line_pred[n_lines] = f_pred[0];
				line_exp[n_lines]  = f_exp;
				n_lines++;
			end else if (code >= 1 && mnem != "#") begin
				abort_run({"malformed stimulus line: ", text});
			end
		end
		$fclose(fd);
		if (n_lines == 0) begin
			abort_run("the stimulus file holds no instructions");
		end
	endtask

	task automatic drive_instruction(input int idx);
		dispatch_valid = 1'b1;
		dispatch_op    = line_op[idx];
		dispatch_a     = line_a[idx];
		dispatch_b     = line_b[idx];
		dispatch_imm   = line_imm[idx];
		dispatch_pc    = line_pc[idx];
		dispatch_rd    = line_rd[idx];
		dispatch_pred  = line_pred[idx];
	endtask

	// retire outputs are registered, so they are steady at the falling edge
	task automatic monitor_outputs(inout int next_idx);
		int idx;
		logic exp_taken;
		if (commit_valid) begin
			if (sb_q.size() == 0) begin
				abort_run("a commit appeared with no instruction outstanding");
			end else begin
				idx = sb_q.pop_front();
				if (is_branch(line_op[idx])) begin
					abort_run($sformatf("a commit appeared where branch line %0d was due", idx));
				end
				check_commit(commit_rd, line_rd[idx], commit_data, line_exp[idx], idx);
				retired++;
			end
		end
		if (br_valid) begin
			if (sb_q.size() == 0) begin
				abort_run("a branch report appeared with no instruction outstanding");
			end else begin
				idx = sb_q.pop_front();
				if (!is_branch(line_op[idx])) begin
					abort_run($sformatf("a branch report appeared where line %0d was due", idx));
				end
				exp_taken = branch_taken(line_op[idx], line_a[idx], line_b[idx]);
				check_branch(br_taken, exp_taken, br_pc, line_pc[idx], idx);
				retired++;
				if (exp_taken != line_pred[idx]) begin
					if (!flush_valid) begin
						report_mismatch($sformatf("no flush for mispredicted line %0d", idx));
					end
					check_flush(flush_pc, line_exp[idx], idx);
					// younger work is gone, refetch from the line after the branch
					sb_q.delete();
					next_idx = idx + 1;
				end else if (flush_valid) begin
					report_mismatch($sformatf("flush after correctly predicted line %0d", idx));
				end
			end
		end else if (flush_valid) begin
			abort_run("a flush appeared without a branch report");
		end
	endtask

	always @(posedge clk) begin
		cycle_count++;
		if (cycle_limit != 0 && cycle_count >= cycle_limit) begin
			$display("timeout: the run did not finish within %0d cycles", cycle_limit);
			end_with_failure();
		end
	end

	initial begin
		int next_idx;
		int gap;
		int spare_idx;
		rst            = 1'b1;
		dispatch_valid = 1'b0;
		dispatch_op    = op_add;
		dispatch_a     = '0;
		dispatch_b     = '0;
		dispatch_imm   = '0;
		dispatch_pc    = '0;
		dispatch_rd    = '0;
		dispatch_pred  = 1'b0;
		seed           = 32'h1bb1_e4ec;
		retired        = 0;
		cycle_count    = 0;
		cycle_limit    = 0;
		load_testdata();
		cycle_limit = 30 * n_lines + 50;

		repeat (2) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;

		next_idx = 0;
		gap = 0;
		while (next_idx < n_lines || sb_q.size() != 0) begin
			monitor_outputs(next_idx);
			if (gap > 0 || next_idx >= n_lines) begin
				dispatch_valid = 1'b0;
				if (gap > 0) begin
					gap--;
				end
			end else begin
				drive_instruction(next_idx);
				#1;
				// ready depends on state and the opcode just driven
				if (dispatch_ready) begin
					if (sb_q.size() >= `ROB_DEPTH) begin
						abort_run("dispatch accepted while the reorder buffer was full");
					end
					sb_q.push_back(next_idx);
					next_idx++;
					gap = $unsigned($random(seed)) % 3;
				end
			end
			@(negedge clk);
		end

		// nothing further may retire
		dispatch_valid = 1'b0;
		spare_idx = n_lines;
		repeat (3) begin
			monitor_outputs(spare_idx);
			@(negedge clk);
		end

		if (retired == n_lines) begin
			$display("NO ERRORS");
			$finish;
		end else begin
			$display("retired %0d instructions, expected %0d", retired, n_lines);
			end_with_failure();
		end
	end

endmodule : rob_core_tb

// ==== testbench/rob_testdata.txt ====
# op a b imm pc rd pred expected, all fields hex
# expected is the result for alu and mul, the next pc for beq and bne
add 00000005 00000003 00000000 00000100 01 0 00000008
sub 0000000a 00000003 00000000 00000104 02 0 00000007
xor ff00ff00 0f0f0f0f 00000000 00000108 03 0 f00ff00f
mul 00000007 00000006 00000000 0000010c 04 0 0000002a
add 00000001 00000001 00000000 00000110 05 0 00000002
sub 00000000 00000001 00000000 00000114 06 0 ffffffff
xor 12345678 ffffffff 00000000 00000118 07 0 edcba987
beq 00000003 00000003 00000010 0000011c 00 1 0000012c
mul 00012345 00000100 00000000 00000120 08 0 01234500
add 80000000 80000000 00000000 00000124 09 0 00000000
bne 00000004 00000004 00000020 00000128 00 0 0000012c
sub 00000100 00000001 00000000 0000012c 0a 0 000000ff
bne 00000001 00000002 00000040 00000130 00 0 00000170
add 00000002 00000002 00000000 00000134 0b 0 00000004
mul ffffffff ffffffff 00000000 00000138 0c 0 00000001
xor aaaaaaaa 55555555 00000000 0000013c 0d 0 ffffffff
beq 00000001 00000002 00000008 00000140 00 1 00000144
add 00000010 00000020 00000000 00000144 0e 0 00000030
sub 00000005 00000005 00000000 00000148 0f 0 00000000
